// ==== video_read_top.f ====
video_read_pkg.sv
window_config.sv
scale_1d.sv
line_reader.sv
asym_ram.sv
mm2s_adv.sv
video_read_top.sv
axi_mem_model.sv
video_read_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the video reader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module video_read_tb -f video_read_top.f -o video_read_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/video_read_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1

// ==== video_read_tb.sv ====
`timescale 1ns/100ps

module video_read_tb import video_read_pkg::*; ();
	localparam int stride = 1024;
	localparam int n_frames = 8;

	logic clk = 1'b0;
	logic resetn = 1'b0;
	logic fsync = 1'b0;
	logic [addr_width-1:0] cfg_frame_addr = '0;
	logic [img_wbits-1:0] cfg_win_left = '0;
	logic [img_wbits-1:0] cfg_win_width = '0;
	logic [img_hbits-1:0] cfg_win_top = '0;
	logic [img_hbits-1:0] cfg_win_height = '0;
	logic [img_wbits-1:0] cfg_dst_width = '0;
	logic [img_hbits-1:0] cfg_dst_height = '0;
	logic cfg_req = 1'b0;
	logic cfg_ack;
	logic frame_done;
	logic [addr_width-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	logic [data_width-1:0] rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;
	logic [pixel_width-1:0] m_axis_tdata;
	logic m_axis_tvalid;
	logic m_axis_tready = 1'b0;
	logic m_axis_tuser;
	logic m_axis_tlast;

	// one row per frame
	logic [addr_width-1:0] fr_addr [n_frames];
	int fr_left [n_frames];
	int fr_w [n_frames];
	int fr_top [n_frames];
	int fr_h [n_frames];
	int fr_dw [n_frames];
	int fr_dh [n_frames];
	bit fr_bp [n_frames];
	bit fr_mid [n_frames];

	logic [pixel_width-1:0] exp_data [$];
	logic exp_user [$];
	logic exp_last [$];
	logic [pixel_width-1:0] want_data;
	logic want_user;
	logic want_last;

	int value_errors = 0;
	int proto_errors = 0;
	int flow_errors = 0;
	int mem_faults;
	int done_count = 0;
	int done_base = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	logic ack_prev = 1'b0;
	logic req_prev = 1'b0;
	logic bp_on = 1'b0;

	always #50 clk = ~clk;

	video_read_top #(.burst_len(16), .img_stride(stride)) dut0 (.*);

	axi_mem_model mem0 (.*, .faults(mem_faults));

	function automatic logic [7:0] mem_byte(input logic [addr_width-1:0] a);
		logic [addr_width-1:0] v;
		v = a * 7 + (a >> 8) + (a >> 16) + (a >> 24);
		return v[7:0];
	endfunction

	task automatic set_frame(input int i, input logic [addr_width-1:0] addr, input int left,
			input int w, input int top, input int h, input int dw, input int dh,
			input bit bp, input bit mid);
		fr_addr[i] = addr;
		fr_left[i] = left;
		fr_w[i] = w;
		fr_top[i] = top;
		fr_h[i] = h;
		fr_dw[i] = dw;
		fr_dh[i] = dh;
		fr_bp[i] = bp;
		fr_mid[i] = mid;
	endtask

	// horizontal ratio kept below 3:1 so the timeout stays meaningful
	task automatic random_frame(input int i);
		int w;
		w = 8 + int'($urandom % 113);
		set_frame(i, 32'h0007_0000 + 32'(i) * 32'h0001_0000, int'($urandom % 300), w,
			int'($urandom % 40), 1 + int'($urandom % 8), w / 3 + 1 + int'($urandom % (2 * w)),
			1 + int'($urandom % 10), ($urandom % 2) == 1, ($urandom % 2) == 1);
	endtask

	// floor index rule for rows and columns
	task automatic build_expected(input int i);
		int k;
		int j;
		int row;
		int col;
		for (k = 0; k < fr_dh[i]; k++) begin
			row = fr_top[i] + (k * fr_h[i]) / fr_dh[i];
			for (j = 0; j < fr_dw[i]; j++) begin
				col = fr_left[i] + (j * fr_w[i]) / fr_dw[i];
				exp_data.push_back(mem_byte(fr_addr[i] + 32'(row * stride + col)));
				exp_user.push_back(k == 0 && j == 0);
				exp_last.push_back(j == fr_dw[i] - 1);
			end
		end
	endtask

	task automatic send_config(input int i);
		@(posedge clk);
		cfg_frame_addr <= fr_addr[i];
		cfg_win_left <= img_wbits'(fr_left[i]);
		cfg_win_width <= img_wbits'(fr_w[i]);
		cfg_win_top <= img_hbits'(fr_top[i]);
		cfg_win_height <= img_hbits'(fr_h[i]);
		cfg_dst_width <= img_wbits'(fr_dw[i]);
		cfg_dst_height <= img_hbits'(fr_dh[i]);
		cfg_req <= 1'b1;
		@(negedge clk);
		while (!cfg_ack) @(negedge clk);
		@(posedge clk);
		cfg_req <= 1'b0;
		// junk on the bus once the request is gone
		cfg_frame_addr <= '1;
		cfg_win_left <= '1;
		@(negedge clk);
		while (cfg_ack) @(negedge clk);
	endtask

	task automatic run_frame(input int i);
		int half;
		build_expected(i);
		half = exp_data.size() / 2;
		done_base = done_count;
		@(posedge clk);
		bp_on <= fr_bp[i];
		fsync <= 1'b1;
		@(posedge clk);
		fsync <= 1'b0;
		if (fr_mid[i] && i + 1 < n_frames) begin
			while (exp_data.size() > half) @(posedge clk);
			send_config(i + 1);
		end
		while (exp_data.size() != 0) @(posedge clk);
		repeat (30) @(posedge clk);
		if (done_count - done_base != 1) begin
			$display("frame %0d: frame_done pulsed %0d times instead of once", i,
				done_count - done_base);
			flow_errors++;
		end
		if (!fr_mid[i] && i + 1 < n_frames) begin
			send_config(i + 1);
		end
	endtask

	always @(posedge clk) begin
		if (bp_on) begin
			m_axis_tready <= ($urandom % 100) >= 40;
		end else begin
			m_axis_tready <= 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// outputs are sampled mid-cycle, a transfer happens at the next rising edge
	always @(negedge clk) begin
		if (resetn && frame_done) begin
			done_count++;
		end
		if (resetn && m_axis_tvalid && m_axis_tready) begin
			if (exp_data.size() == 0) begin
				$display("a pixel was sent on the stream while no frame was expected");
				proto_errors++;
			end else begin
				want_data = exp_data.pop_front();
				want_user = exp_user.pop_front();
				want_last = exp_last.pop_front();
				if (m_axis_tdata !== want_data) begin
					$display("CHECK FAILED: m_axis_tdata got 0x%h expected 0x%h",
						m_axis_tdata, want_data);
					value_errors++;
				end
				if (m_axis_tuser !== want_user) begin
					$display("CHECK FAILED: m_axis_tuser got 0x%h expected 0x%h",
						m_axis_tuser, want_user);
					value_errors++;
				end
				if (m_axis_tlast !== want_last) begin
					$display("CHECK FAILED: m_axis_tlast got 0x%h expected 0x%h",
						m_axis_tlast, want_last);
					value_errors++;
				end
				if (exp_data.size() == 0 && done_count != done_base + 1) begin
					$display("frame_done did not pulse before the last line was streamed");
					proto_errors++;
				end
			end
		end
		if (cfg_ack && !ack_prev && !req_prev) begin
			$display("cfg_ack rose while no request was pending");
			proto_errors++;
		end
		if (!cfg_ack && ack_prev && req_prev) begin
			$display("cfg_ack fell while cfg_req was still high");
			proto_errors++;
		end
		ack_prev = cfg_ack;
		req_prev = cfg_req;
	end

	initial begin
		int i;
		int total;
		void'($urandom(44));
		set_frame(0, 32'h0001_0000, 0, 64, 0, 4, 64, 4, 1'b0, 1'b0);
		set_frame(1, 32'h0002_0000, 101, 50, 3, 5, 50, 5, 1'b0, 1'b0);
		set_frame(2, 32'h0003_0000, 13, 90, 2, 9, 31, 4, 1'b0, 1'b0);
		set_frame(3, 32'h0004_0000, 70, 20, 1, 3, 47, 7, 1'b0, 1'b0);
		// the next window is loaded halfway through this frame
		set_frame(4, 32'h0005_0000, 6, 77, 5, 6, 60, 8, 1'b1, 1'b1);
		set_frame(5, 32'h0006_0000, 130, 33, 7, 5, 33, 5, 1'b1, 1'b0);
		for (i = 6; i < n_frames; i++) begin
			random_frame(i);
		end
		cycle_limit = 2000;
		for (i = 0; i < n_frames; i++) begin
			cycle_limit += 40 * fr_dw[i] * fr_dh[i] + 2000;
		end
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		send_config(0);
		for (i = 0; i < n_frames; i++) begin
			run_frame(i);
		end
		repeat (20) @(posedge clk);
		total = value_errors + proto_errors + flow_errors + mem_faults;
		$display("errors: %0d value, %0d protocol, %0d frame, %0d memory", value_errors,
			proto_errors, flow_errors, mem_faults);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model import video_read_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic [addr_width-1:0] araddr,
	input  logic [7:0] arlen,
	input  logic arvalid,
	output logic arready,
	output logic [data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input  logic rready,
	output int faults
);
	logic busy;
	logic [addr_width-1:0] beat_addr;
	logic [7:0] beats_left;

	// a times 7 plus a >> 8, with the upper address bytes folded in as well
	function automatic logic [7:0] byte_at(input logic [addr_width-1:0] a);
		logic [addr_width-1:0] v;
		v = a * 7 + (a >> 8) + (a >> 16) + (a >> 24);
		return v[7:0];
	endfunction

	// byte lane 0 holds the lowest address
	function automatic logic [data_width-1:0] word_at(input logic [addr_width-1:0] a);
		logic [data_width-1:0] w;
		for (int b = 0; b < adata_pixels; b++) begin
			w[b*8 +: 8] = byte_at(a + addr_width'(b));
		end
		return w;
	endfunction

	initial begin
		arready = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		rlast = 1'b0;
		rvalid = 1'b0;
		faults = 0;
	end

	always @(posedge clk) begin
		if (!resetn) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rresp <= 2'b00;
			busy <= 1'b0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				if (arlen > 8'd15) begin
					$display("memory model: burst of %0d beats is longer than 16", arlen + 1);
					faults <= faults + 1;
				end
				busy <= 1'b1;
				arready <= 1'b0;
				beat_addr <= araddr;
				beats_left <= arlen;
			end else begin
				arready <= ($urandom % 4) != 0;
			end
		end else begin
			if (!rready) begin
				$display("memory model: rready dropped in the middle of a burst");
				faults <= faults + 1;
			end
			if (!rvalid || rready) begin
				if (rvalid && rlast) begin
					busy <= 1'b0;
					rvalid <= 1'b0;
					rlast <= 1'b0;
				end else if (($urandom % 3) != 0) begin
					rvalid <= 1'b1;
					rlast <= (beats_left == 8'd0);
					rdata <= word_at(beat_addr);
					beat_addr <= beat_addr + 4;
					beats_left <= beats_left - 8'd1;
				end else begin
					// gap between beats
					rvalid <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== video_read_top.sv ====
`timescale 1ns/100ps

module video_read_top import video_read_pkg::*; #(
	parameter int burst_len = default_burst_len,
	parameter int img_stride = default_img_stride
) (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic [addr_width-1:0] cfg_frame_addr,
	input  logic [img_wbits-1:0] cfg_win_left,
	input  logic [img_wbits-1:0] cfg_win_width,
	input  logic [img_hbits-1:0] cfg_win_top,
	input  logic [img_hbits-1:0] cfg_win_height,
	input  logic [img_wbits-1:0] cfg_dst_width,
	input  logic [img_hbits-1:0] cfg_dst_height,
	input  logic cfg_req,
	output logic cfg_ack,
	output logic frame_done,
	output logic [addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input  logic arready,
	input  logic [data_width-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output logic [pixel_width-1:0] m_axis_tdata,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic m_axis_tuser,
	output logic m_axis_tlast
);
	// active geometry, registered at fsync inside cfg0
	logic [addr_width-1:0] frame_addr;
	logic [addr_width-1:0] frame_offset;
	logic [img_wbits-1:0] fetch_pixels;
	logic [img_wbits-1:0] read_offset;
	logic [img_wbits-1:0] win_width;
	logic [img_hbits-1:0] win_height;
	logic [img_wbits-1:0] dst_width;
	logic [img_hbits-1:0] dst_height;

	window_config #(.burst_len(burst_len), .img_stride(img_stride)) cfg0 (.*);

	mm2s_adv #(.burst_len(burst_len), .img_stride(img_stride)) core0 (.*);

endmodule

// ==== mm2s_adv.sv ====
`timescale 1ns/100ps

module mm2s_adv import video_read_pkg::*; #(
	parameter int burst_len = default_burst_len,
	parameter int img_stride = default_img_stride
) (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic [addr_width-1:0] frame_addr,
	input  logic [addr_width-1:0] frame_offset,
	input  logic [img_wbits-1:0] fetch_pixels,
	input  logic [img_wbits-1:0] read_offset,
	input  logic [img_wbits-1:0] win_width,
	input  logic [img_hbits-1:0] win_height,
	input  logic [img_wbits-1:0] dst_width,
	input  logic [img_hbits-1:0] dst_height,
	output logic frame_done,
	output logic [addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input  logic arready,
	input  logic [data_width-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready,
	output logic [pixel_width-1:0] m_axis_tdata,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic m_axis_tuser,
	output logic m_axis_tlast
);
	localparam int word_bits = img_wbits - adata_bits;

	logic fsync_d1;
	logic [1:0] buf_writing;
	logic [1:0] buf_reading;
	logic [1:0] buf_full;
	logic is_writing;
	logic is_reading;
	logic sol_read;
	logic eol_read;
	logic eol_write;
	logic writing_last;
	logic line_valid;
	logic line_ready;
	logic line_last;
	logic line_fire;
	logic [addr_width-1:0] line_addr;
	logic wr_en;
	logic [word_bits-1:0] wr_addr;
	logic [data_width-1:0] wr_data;
	logic pix_valid;
	logic pix_ready;
	logic pix_last;
	logic pix_fire;
	logic [img_wbits-1:0] pix_addr;
	logic [pixel_width-1:0] rd_a;
	logic [pixel_width-1:0] rd_b;
	logic rd_sel;

	// geometry from window_config settles one cycle after fsync
	always_ff @(posedge clk) begin
		if (!resetn) begin
			fsync_d1 <= 1'b0;
		end else begin
			fsync_d1 <= fsync;
		end
	end

	assign line_ready = ((buf_writing & buf_full) == 2'b00) && !is_writing;
	assign line_fire = line_valid && line_ready;

	scale_1d #(.width_bits(img_hbits), .addr_bits(addr_width)) height_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(fsync_d1),
		.s_width(win_height),
		.m_width(dst_height),
		.base_addr(frame_addr),
		.off_addr(frame_offset),
		.inc_addr(addr_width'(img_stride)),
		.o_ready(line_ready),
		.o_valid(line_valid),
		.o_last(line_last),
		.o_addr(line_addr)
	);

	line_reader #(.burst_len(burst_len), .addr_width(addr_width)) reader0 (
		.clk(clk),
		.resetn(resetn),
		.sol(line_fire),
		.line_addr(line_addr),
		.fetch_pixels(fetch_pixels),
		.end_of_line(eol_write),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	asym_ram #(
		.wr_data_width(data_width),
		.wr_addr_width(word_bits),
		.rd_data_width(pixel_width),
		.rd_addr_width(img_wbits)
	) buf_a (
		.clk(clk),
		.we(wr_en && buf_writing[0]),
		.wa(wr_addr),
		.wd(wr_data),
		.re(pix_fire && buf_reading[0]),
		.ra(pix_addr),
		.rd(rd_a)
	);

	asym_ram #(
		.wr_data_width(data_width),
		.wr_addr_width(word_bits),
		.rd_data_width(pixel_width),
		.rd_addr_width(img_wbits)
	) buf_b (
		.clk(clk),
		.we(wr_en && buf_writing[1]),
		.wa(wr_addr),
		.wd(wr_data),
		.re(pix_fire && buf_reading[1]),
		.ra(pix_addr),
		.rd(rd_b)
	);

	// ping-pong pointers rotate at the end of each written or streamed line
	always_ff @(posedge clk) begin
		if (!resetn) begin
			buf_writing <= 2'b00;
			buf_reading <= 2'b00;
			buf_full <= 2'b00;
		end else if (fsync) begin
			buf_writing <= 2'b01;
			buf_reading <= 2'b01;
			buf_full <= 2'b00;
		end else begin
			if (eol_write) begin
				buf_writing <= {buf_writing[0], buf_writing[1]};
			end
			if (eol_read) begin
				buf_reading <= {buf_reading[0], buf_reading[1]};
			end
			buf_full <= (buf_full | (buf_writing & {2{eol_write}}))
				& ~(buf_reading & {2{eol_read}});
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || fsync) begin
			is_writing <= 1'b0;
		end else if (line_fire) begin
			is_writing <= 1'b1;
		end else if (eol_write) begin
			is_writing <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (line_fire) begin
			writing_last <= line_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= eol_write && writing_last;
		end
	end

	// read side starts a line once the buffer it points at is full
	always_ff @(posedge clk) begin
		if (!resetn || fsync) begin
			sol_read <= 1'b0;
			is_reading <= 1'b0;
			eol_read <= 1'b0;
		end else begin
			sol_read <= !sol_read && !is_reading && ((buf_full & buf_reading) != 2'b00);
			eol_read <= m_axis_tvalid && m_axis_tready && m_axis_tlast;
			if (sol_read) begin
				is_reading <= 1'b1;
			end else if (eol_read) begin
				is_reading <= 1'b0;
			end
		end
	end

	assign pix_ready = is_reading && (!m_axis_tvalid || m_axis_tready);
	assign pix_fire = pix_valid && pix_ready;

	scale_1d #(.width_bits(img_wbits), .addr_bits(img_wbits)) width_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(sol_read),
		.s_width(win_width),
		.m_width(dst_width),
		.base_addr('0),
		.off_addr(read_offset),
		.inc_addr(img_wbits'(1)),
		.o_ready(pix_ready),
		.o_valid(pix_valid),
		.o_last(pix_last),
		.o_addr(pix_addr)
	);

	// stream output stage
	always_ff @(posedge clk) begin
		if (pix_fire) begin
			rd_sel <= buf_reading[1];
		end
	end

	assign m_axis_tdata = rd_sel ? rd_b : rd_a;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
		end else if (pix_fire) begin
			m_axis_tvalid <= 1'b1;
			m_axis_tlast <= pix_last;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_tuser <= 1'b0;
		end else if (fsync) begin
			m_axis_tuser <= 1'b1;
		end else if (m_axis_tvalid && m_axis_tready) begin
			m_axis_tuser <= 1'b0;
		end
	end

endmodule

// ==== asym_ram.sv ====
`timescale 1ns/100ps

module asym_ram #(
	parameter int wr_data_width = 32,
	parameter int wr_addr_width = 10,
	parameter int rd_data_width = 8,
	parameter int rd_addr_width = 12
) (
	input  logic clk,
	input  logic we,
	input  logic [wr_addr_width-1:0] wa,
	input  logic [wr_data_width-1:0] wd,
	input  logic re,
	input  logic [rd_addr_width-1:0] ra,
	output logic [rd_data_width-1:0] rd
);
	localparam int sel_bits = rd_addr_width - wr_addr_width;

	logic [wr_data_width-1:0] mem [2**wr_addr_width];
	logic [wr_addr_width-1:0] ra_word;
	logic [sel_bits-1:0] ra_sel;

	assign ra_word = ra[rd_addr_width-1:sel_bits];
	assign ra_sel = ra[sel_bits-1:0];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wa] <= wd;
		end
	end

	// pixel 0 is in the low byte lane of the word
	always_ff @(posedge clk) begin
		if (re) begin
			rd <= mem[ra_word][ra_sel*rd_data_width +: rd_data_width];
		end
	end

endmodule

// ==== line_reader.sv ====
`timescale 1ns/100ps

module line_reader import video_read_pkg::*; #(
	parameter int burst_len = default_burst_len,
	parameter int addr_width = 32
) (
	input  logic clk,
	input  logic resetn,
	input  logic sol,
	input  logic [addr_width-1:0] line_addr,
	input  logic [img_wbits-1:0] fetch_pixels,
	output logic end_of_line,
	output logic wr_en,
	output logic [img_wbits-adata_bits-1:0] wr_addr,
	output logic [data_width-1:0] wr_data,
	output logic [addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input  logic arready,
	input  logic [data_width-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic rvalid,
	output logic rready
);
	localparam int word_bits = img_wbits - adata_bits;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_addr,
		st_data
	} state_t;

	state_t state;
	logic beat;
	logic [word_bits-1:0] words_left;
	logic [word_bits-1:0] burst_words;
	logic [addr_width-1:0] next_addr;

	assign burst_words = (words_left > word_bits'(burst_len))
		? word_bits'(burst_len) : words_left;

	assign rready = (state != st_idle);
	assign beat = rvalid && rready;
	assign wr_en = beat;
	// error beats are stored as black pixels
	assign wr_data = rresp[1] ? '0 : rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
			arvalid <= 1'b0;
			end_of_line <= 1'b0;
		end else begin
			end_of_line <= 1'b0;
			case (state)
				st_idle: begin
					if (sol) begin
						state <= st_issue;
					end
				end
				st_issue: begin
					arvalid <= 1'b1;
					state <= st_addr;
				end
				st_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						state <= st_data;
					end
				end
				default: begin
					if (beat && rlast) begin
						if (words_left == '0) begin
							state <= st_idle;
							end_of_line <= 1'b1;
						end else begin
							state <= st_issue;
						end
					end
				end
			endcase
		end
	end

	// one byte per pixel, so a word advances the address by adata_pixels
	always_ff @(posedge clk) begin
		if (state == st_idle && sol) begin
			words_left <= fetch_pixels[img_wbits-1:adata_bits];
			next_addr <= line_addr;
			wr_addr <= '0;
		end else if (state == st_issue) begin
			araddr <= next_addr;
			arlen <= 8'(burst_words - 1'b1);
			words_left <= words_left - burst_words;
			next_addr <= next_addr + (addr_width'(burst_words) << adata_bits);
		end else if (beat) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

endmodule

// ==== scale_1d.sv ====
`timescale 1ns/100ps

module scale_1d #(
	parameter int width_bits = 12,
	parameter int addr_bits = 32
) (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  logic [width_bits-1:0] s_width,
	input  logic [width_bits-1:0] m_width,
	input  logic [addr_bits-1:0] base_addr,
	input  logic [addr_bits-1:0] off_addr,
	input  logic [addr_bits-1:0] inc_addr,
	input  logic o_ready,
	output logic o_valid,
	output logic o_last,
	output logic [addr_bits-1:0] o_addr
);
	logic stepping;
	logic fire;
	logic [width_bits-1:0] count;
	// one extra bit so that remainder plus s_width cannot wrap
	logic [width_bits:0] rem;
	logic [width_bits:0] m_ext;
	logic [width_bits:0] rem_src;
	logic [width_bits:0] rem_sub;
	logic step_now;
	logic step_more;

	assign m_ext = {1'b0, m_width};
	assign fire = o_valid && o_ready;

	// a new output adds s_width, stepping only takes m_width away
	assign rem_src = stepping ? rem : rem + {1'b0, s_width};
	assign rem_sub = rem_src - m_ext;
	assign step_now = (rem_src >= m_ext);
	assign step_more = step_now && (rem_sub >= m_ext);

	assign o_last = (count == m_width - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_valid <= 1'b0;
			stepping <= 1'b0;
		end else if (start) begin
			o_valid <= (m_width != '0);
			stepping <= 1'b0;
		end else if (fire) begin
			if (o_last) begin
				o_valid <= 1'b0;
			end else if (step_more) begin
				o_valid <= 1'b0;
				stepping <= 1'b1;
			end
		end else if (stepping && rem_sub < m_ext) begin
			stepping <= 1'b0;
			o_valid <= 1'b1;
		end
	end

	// quotient lives in o_addr as a multiple of inc_addr
	always_ff @(posedge clk) begin
		if (start) begin
			count <= '0;
			rem <= '0;
			o_addr <= base_addr + off_addr;
		end else if (fire && !o_last) begin
			count <= count + 1'b1;
			if (step_now) begin
				rem <= rem_sub;
				o_addr <= o_addr + inc_addr;
			end else begin
				rem <= rem_src;
			end
		end else if (stepping) begin
			rem <= rem_sub;
			o_addr <= o_addr + inc_addr;
		end
	end

endmodule

// ==== window_config.sv ====
`timescale 1ns/100ps

module window_config import video_read_pkg::*; #(
	parameter int burst_len = default_burst_len,
	parameter int img_stride = default_img_stride
) (
	input  logic clk,
	input  logic resetn,
	input  logic fsync,
	input  logic [addr_width-1:0] cfg_frame_addr,
	input  logic [img_wbits-1:0] cfg_win_left,
	input  logic [img_wbits-1:0] cfg_win_width,
	input  logic [img_hbits-1:0] cfg_win_top,
	input  logic [img_hbits-1:0] cfg_win_height,
	input  logic [img_wbits-1:0] cfg_dst_width,
	input  logic [img_hbits-1:0] cfg_dst_height,
	input  logic cfg_req,
	output logic cfg_ack,
	output logic [addr_width-1:0] frame_addr,
	output logic [addr_width-1:0] frame_offset,
	output logic [img_wbits-1:0] fetch_pixels,
	output logic [img_wbits-1:0] read_offset,
	output logic [img_wbits-1:0] win_width,
	output logic [img_hbits-1:0] win_height,
	output logic [img_wbits-1:0] dst_width,
	output logic [img_hbits-1:0] dst_height
);
	localparam int index_bits = burst_index_bits(burst_len);

	logic [addr_width-1:0] pend_frame_addr;
	logic [img_wbits-1:0] pend_win_left;
	logic [img_wbits-1:0] pend_win_width;
	logic [img_hbits-1:0] pend_win_top;
	logic [img_hbits-1:0] pend_win_height;
	logic [img_wbits-1:0] pend_dst_width;
	logic [img_hbits-1:0] pend_dst_height;
	logic [img_wbits-1:0] aligned_left;
	logic [img_wbits-1:0] head_pixels;
	logic [img_wbits-1:0] fetch_raw;
	logic capture;

	// take the data on the first cycle of a request
	assign capture = cfg_req && !cfg_ack;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg_ack <= 1'b0;
		end else if (capture) begin
			cfg_ack <= 1'b1;
		end else if (!cfg_req && cfg_ack) begin
			cfg_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			pend_frame_addr <= cfg_frame_addr;
			pend_win_left <= cfg_win_left;
			pend_win_width <= cfg_win_width;
			pend_win_top <= cfg_win_top;
			pend_win_height <= cfg_win_height;
			pend_dst_width <= cfg_dst_width;
			pend_dst_height <= cfg_dst_height;
		end
	end

	// fetch starts on a burst boundary, the head is skipped when reading out
	assign aligned_left = {pend_win_left[img_wbits-1:index_bits], {index_bits{1'b0}}};
	assign head_pixels = {{(img_wbits-index_bits){1'b0}}, pend_win_left[index_bits-1:0]};
	assign fetch_raw = head_pixels + pend_win_width + img_wbits'(adata_pixels - 1);

	always_ff @(posedge clk) begin
		if (fsync) begin
			frame_addr <= pend_frame_addr;
			frame_offset <= addr_width'(aligned_left)
				+ addr_width'(pend_win_top) * addr_width'(img_stride);
			fetch_pixels <= {fetch_raw[img_wbits-1:adata_bits], {adata_bits{1'b0}}};
			read_offset <= head_pixels;
			win_width <= pend_win_width;
			win_height <= pend_win_height;
			dst_width <= pend_dst_width;
			dst_height <= pend_dst_height;
		end
	end

endmodule

// ==== video_read_pkg.sv ====
package video_read_pkg;

	// pixel format, one byte per pixel in memory
	localparam int pixel_width = 8;

	// memory bus
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int adata_pixels = data_width / pixel_width;
	localparam int adata_bits = $clog2(adata_pixels);

	// image geometry counters
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	// defaults for the top level parameters
	localparam int default_burst_len = 16;
	localparam int default_img_stride = 1024;

	function automatic int burst_pixels(int burst_len);
		return adata_pixels * burst_len;
	endfunction

	function automatic int burst_index_bits(int burst_len);
		return $clog2(burst_pixels(burst_len));
	endfunction

endpackage
